/* rtl/analog_pkg.sv */
/*
 * Shared sizes for the analog data path
 * Raw ADC width, processed sample width, averaging window constants, sample type
 */

`default_nettype none

package analog_pkg;

  //////////////////////////////////////////////////////////////////////
  // ADC input side
  //////////////////////////////////////////////////////////////////////

  localparam int ADC_RAW_W  = 16;  // Raw converter word
  localparam int ADC_DROP_W = 2;   // Low bits reserved for 16-bit parts

  //////////////////////////////////////////////////////////////////////
  // Processed samples
  //////////////////////////////////////////////////////////////////////

  // Width of every stream between blocks, ADC and DAC alike
  localparam int SMP_W = ADC_RAW_W - ADC_DROP_W;

  //////////////////////////////////////////////////////////////////////
  // Boxcar window on DAC channel A
  //////////////////////////////////////////////////////////////////////

  localparam int AVG_LOG2  = 6;               // Window depth as power of two
  localparam int AVG_LEN   = 1 << AVG_LOG2;   // 64 samples
  localparam int AVG_SUM_W = SMP_W + AVG_LOG2; // Running sum, no overflow

  // Two's complement sample, one per clock on every stream
  typedef logic signed [SMP_W-1:0] sample_t;

endpackage

`default_nettype wire

/* rtl/adc_frontend.sv */
/*
 * ADC input stage
 * Raw word capture, negative-slope to two's complement, digital loopback
 */

`timescale 1ns/1ps
`default_nettype none

module adc_frontend (
  input  logic                               adc_clk,
  input  logic                               adc_rstn,
  input  logic [analog_pkg::ADC_RAW_W-1:0]   adc_a_i,   // Raw converter word CH A
  input  logic [analog_pkg::ADC_RAW_W-1:0]   adc_b_i,   // Raw converter word CH B
  input  logic                               loop_en_i, // Feed DAC mix back to acq
  input  analog_pkg::sample_t                mix_a_i,   // Loopback source CH A
  input  analog_pkg::sample_t                mix_b_i,   // Loopback source CH B
  output analog_pkg::sample_t                adc_a_o,
  output analog_pkg::sample_t                adc_b_o
);

  import analog_pkg::*;

  logic [SMP_W-1:0] raw_a_q;  // Upper bits only
  logic [SMP_W-1:0] raw_b_q;
  sample_t          conv_a;
  sample_t          conv_b;

  //////////////////////////////////////////////////////////////////////
  // Input register, would sit in the IO block on silicon
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      raw_a_q <= '0;
      raw_b_q <= '0;
    end else begin
      raw_a_q <= adc_a_i[ADC_RAW_W-1:ADC_DROP_W];  // Drop 2 LSBs
      raw_b_q <= adc_b_i[ADC_RAW_W-1:ADC_DROP_W];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Code conversion and loopback
  //////////////////////////////////////////////////////////////////////

  // Negative slope code: keep MSB, flip the rest
  assign conv_a = {raw_a_q[SMP_W-1], ~raw_a_q[SMP_W-2:0]};
  assign conv_b = {raw_b_q[SMP_W-1], ~raw_b_q[SMP_W-2:0]};

  // Loopback bypasses the converter entirely
  assign adc_a_o = loop_en_i ? mix_a_i : conv_a;
  assign adc_b_o = loop_en_i ? mix_b_i : conv_b;

endmodule

`default_nettype wire

/* rtl/dac_mixer.sv */
/*
 * DAC mixer
 * Generator plus controller per channel, saturated to 14 bits, registered
 */

`timescale 1ns/1ps
`default_nettype none

module dac_mixer (
  input  logic                adc_clk,
  input  logic                adc_rstn,
  input  analog_pkg::sample_t gen_a_i,  // Signal generator CH A
  input  analog_pkg::sample_t gen_b_i,  // Signal generator CH B
  input  analog_pkg::sample_t ctl_a_i,  // Controller output CH A
  input  analog_pkg::sample_t ctl_b_i,  // Controller output CH B
  output analog_pkg::sample_t mix_a_o,
  output analog_pkg::sample_t mix_b_o
);

  import analog_pkg::*;

  logic signed [SMP_W:0] sum_a;  // One guard bit
  logic signed [SMP_W:0] sum_b;
  sample_t               sat_a;
  sample_t               sat_b;

  // Clamp a one-bit-wide sum back into the sample range
  function automatic sample_t saturate(input logic signed [SMP_W:0] sum);
    sample_t res;
    if (sum[SMP_W] ^ sum[SMP_W-1]) begin    // Top two bits disagree
      res = {sum[SMP_W], {(SMP_W-1){~sum[SMP_W]}}};  // 0x1FFF or 0x2000
    end else begin
      res = sum[SMP_W-1:0];
    end
    return res;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Sum and saturate
  //////////////////////////////////////////////////////////////////////

  assign sum_a = gen_a_i + ctl_a_i;  // Sign extended to 15 bits
  assign sum_b = gen_b_i + ctl_b_i;

  assign sat_a = saturate(sum_a);
  assign sat_b = saturate(sum_b);

  // Output register
  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      mix_a_o <= '0;
      mix_b_o <= '0;
    end else begin
      mix_a_o <= sat_a;
      mix_b_o <= sat_b;
    end
  end

endmodule

`default_nettype wire

/* rtl/boxcar_average.sv */
/*
 * Running average over a 64 sample window
 * Circular buffer with wrapping index, running sum, arithmetic shift out
 */

`timescale 1ns/1ps
`default_nettype none

module boxcar_average (
  input  logic                adc_clk,
  input  logic                adc_rstn,
  input  analog_pkg::sample_t smp_i,  // New sample every clock
  output analog_pkg::sample_t avg_o   // floor(window sum / 64)
);

  import analog_pkg::*;

  sample_t                     win_q [AVG_LEN];  // Last AVG_LEN samples
  logic [AVG_LOG2-1:0]         idx_q;            // Oldest entry, next to overwrite
  logic signed [AVG_SUM_W-1:0] sum_q;            // Sum of whole window
  logic signed [AVG_SUM_W-1:0] sum_nxt;
  logic signed [AVG_SUM_W-1:0] sum_shr;
  sample_t                     old_smp;

  //////////////////////////////////////////////////////////////////////
  // Window update
  //////////////////////////////////////////////////////////////////////

  assign old_smp = win_q[idx_q];  // Leaves the window this cycle

  // All operands signed, so both samples sign extend to sum width
  assign sum_nxt = sum_q + smp_i - old_smp;

  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      idx_q <= '0;
      sum_q <= '0;
      for (int i = 0; i < AVG_LEN; i++) begin
        win_q[i] <= '0;  // Restart with an all zero window
      end
    end else begin
      win_q[idx_q] <= smp_i;      // Overwrite oldest
      sum_q        <= sum_nxt;
      idx_q        <= idx_q + 1'b1; // Wraps at 64 by width
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Output scaling
  //////////////////////////////////////////////////////////////////////

  // Arithmetic shift rounds toward minus infinity
  assign sum_shr = sum_q >>> AVG_LOG2;

  // Shifted sum always fits the sample range
  assign avg_o = sum_shr[SMP_W-1:0];

endmodule

`default_nettype wire

/* rtl/dac_backend.sv */
/*
 * DAC output register
 * Two's complement samples to negative-slope offset code, both channels
 */

`timescale 1ns/1ps
`default_nettype none

module dac_backend (
  input  logic                           adc_clk,
  input  logic                           adc_rstn,
  input  analog_pkg::sample_t            dac_a_i,  // Averaged CH A
  input  analog_pkg::sample_t            dac_b_i,  // Mixed CH B, no averaging
  output logic [analog_pkg::SMP_W-1:0]   dac_a_o,  // Converter code CH A
  output logic [analog_pkg::SMP_W-1:0]   dac_b_o   // Converter code CH B
);

  import analog_pkg::*;

  logic [SMP_W-1:0] code_a;
  logic [SMP_W-1:0] code_b;

  // Keep sign bit, invert magnitude bits
  function automatic logic [SMP_W-1:0] to_dac_code(input sample_t smp);
    return {smp[SMP_W-1], ~smp[SMP_W-2:0]};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Formatting
  //////////////////////////////////////////////////////////////////////

  assign code_a = to_dac_code(dac_a_i);
  assign code_b = to_dac_code(dac_b_i);

  // Converter pins see stable registered codes
  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      dac_a_o <= '0;
      dac_b_o <= '0;
    end else begin
      dac_a_o <= code_a;
      dac_b_o <= code_b;
    end
  end

endmodule

`default_nettype wire

/* rtl/analog_top.sv */
/*
 * Analog data path top level
 * ADC frontend, DAC mixer, channel A boxcar average, DAC backend
 */

`timescale 1ns/1ps
`default_nettype none

module analog_top (
  input  logic                               adc_clk,
  input  logic                               adc_rstn,
  // ADC pins
  input  logic [analog_pkg::ADC_RAW_W-1:0]   adc_a_i,
  input  logic [analog_pkg::ADC_RAW_W-1:0]   adc_b_i,
  input  logic                               loop_en_i,  // Digital loopback
  // Generator and controller streams
  input  analog_pkg::sample_t                gen_a_i,
  input  analog_pkg::sample_t                gen_b_i,
  input  analog_pkg::sample_t                ctl_a_i,
  input  analog_pkg::sample_t                ctl_b_i,
  // Acquisition stream out
  output analog_pkg::sample_t                adc_a_o,
  output analog_pkg::sample_t                adc_b_o,
  // DAC pins
  output logic [analog_pkg::SMP_W-1:0]       dac_a_o,
  output logic [analog_pkg::SMP_W-1:0]       dac_b_o
);

  import analog_pkg::*;

  sample_t mix_a;  // Saturated mix, also loopback source
  sample_t mix_b;
  sample_t avg_a;  // Channel A after averaging

  //////////////////////////////////////////////////////////////////////
  // Acquisition side
  //////////////////////////////////////////////////////////////////////

  adc_frontend i_adc_frontend (
    .adc_clk   (adc_clk  ),
    .adc_rstn  (adc_rstn ),
    .adc_a_i   (adc_a_i  ),
    .adc_b_i   (adc_b_i  ),
    .loop_en_i (loop_en_i),
    .mix_a_i   (mix_a    ),
    .mix_b_i   (mix_b    ),
    .adc_a_o   (adc_a_o  ),
    .adc_b_o   (adc_b_o  )
  );

  //////////////////////////////////////////////////////////////////////
  // Generation side
  //////////////////////////////////////////////////////////////////////

  dac_mixer i_dac_mixer (
    .adc_clk  (adc_clk ),
    .adc_rstn (adc_rstn),
    .gen_a_i  (gen_a_i ),
    .gen_b_i  (gen_b_i ),
    .ctl_a_i  (ctl_a_i ),
    .ctl_b_i  (ctl_b_i ),
    .mix_a_o  (mix_a   ),
    .mix_b_o  (mix_b   )
  );

  // Only channel A is smoothed
  boxcar_average i_boxcar_average (
    .adc_clk  (adc_clk ),
    .adc_rstn (adc_rstn),
    .smp_i    (mix_a   ),
    .avg_o    (avg_a   )
  );

  dac_backend i_dac_backend (
    .adc_clk  (adc_clk ),
    .adc_rstn (adc_rstn),
    .dac_a_i  (avg_a   ),
    .dac_b_i  (mix_b   ),  // Straight through, no window
    .dac_a_o  (dac_a_o ),
    .dac_b_o  (dac_b_o )
  );

endmodule

`default_nettype wire

/* dv/analog_asserts.sv */
/*
 * Concurrent checks bound onto the DAC mixer
 * Clamp limits on overflow, zero mix values after a reset edge
 */

`timescale 1ns/1ps
`default_nettype none

module analog_asserts (
  input logic                              adc_clk,
  input logic                              adc_rstn,
  input logic signed [analog_pkg::SMP_W:0] sum_a_i,  // Unsaturated sums
  input logic signed [analog_pkg::SMP_W:0] sum_b_i,
  input analog_pkg::sample_t               mix_a_i,  // Registered mix
  input analog_pkg::sample_t               mix_b_i
);

  import analog_pkg::*;

  localparam int POS_LIM = 2**(SMP_W-1) - 1;  // 0x1FFF
  localparam int NEG_LIM = -(2**(SMP_W-1));   // 0x2000 as a code

  int fail_cnt = 0;  // Failed assertions so far

  //////////////////////////////////////////////////////////////////////
  // Saturation range
  //////////////////////////////////////////////////////////////////////

  a_clamp_hi_a: assert property (@(posedge adc_clk) disable iff (!adc_rstn)
    int'(sum_a_i) > POS_LIM |=> mix_a_i == sample_t'(POS_LIM))
    else begin
      $error("mix_a above range was not clamped to the positive limit");
      fail_cnt++;
    end

  a_clamp_lo_a: assert property (@(posedge adc_clk) disable iff (!adc_rstn)
    int'(sum_a_i) < NEG_LIM |=> mix_a_i == sample_t'(NEG_LIM))
    else begin
      $error("mix_a below range was not clamped to the negative limit");
      fail_cnt++;
    end

  a_clamp_hi_b: assert property (@(posedge adc_clk) disable iff (!adc_rstn)
    int'(sum_b_i) > POS_LIM |=> mix_b_i == sample_t'(POS_LIM))
    else begin
      $error("mix_b above range was not clamped to the positive limit");
      fail_cnt++;
    end

  a_clamp_lo_b: assert property (@(posedge adc_clk) disable iff (!adc_rstn)
    int'(sum_b_i) < NEG_LIM |=> mix_b_i == sample_t'(NEG_LIM))
    else begin
      $error("mix_b below range was not clamped to the negative limit");
      fail_cnt++;
    end

  // Reset edge leaves both mix registers at zero
  a_reset_zero: assert property (@(posedge adc_clk)
    !adc_rstn |=> (mix_a_i == '0 && mix_b_i == '0))
    else begin
      $error("mix values not zero after a reset edge");
      fail_cnt++;
    end

endmodule

`default_nettype wire

/* dv/analog_checker.sv */
/*
 * Reference model and comparison for the analog data path
 * Register models, 64 entry window, error and clamp counters
 */

`timescale 1ns/1ps
`default_nettype none

module analog_checker (
  input  logic                             adc_clk,
  input  logic                             adc_rstn,
  input  logic [analog_pkg::ADC_RAW_W-1:0] adc_a_i,   // DUT stimulus
  input  logic [analog_pkg::ADC_RAW_W-1:0] adc_b_i,
  input  logic                             loop_en_i,
  input  analog_pkg::sample_t              gen_a_i,
  input  analog_pkg::sample_t              gen_b_i,
  input  analog_pkg::sample_t              ctl_a_i,
  input  analog_pkg::sample_t              ctl_b_i,
  input  analog_pkg::sample_t              acq_a_i,   // DUT adc_a_o
  input  analog_pkg::sample_t              acq_b_i,   // DUT adc_b_o
  input  logic [analog_pkg::SMP_W-1:0]     dac_a_i,   // DUT dac_a_o
  input  logic [analog_pkg::SMP_W-1:0]     dac_b_i,   // DUT dac_b_o
  output int                               err_cnt_o,
  output int                               chk_cnt_o,
  output int                               sat_hi_cnt_o,
  output int                               sat_lo_cnt_o
);

  import analog_pkg::*;

  localparam int SAT_MAX = 2**(SMP_W-1) - 1;
  localparam int SAT_MIN = -(2**(SMP_W-1));

  logic [SMP_W-1:0] raw_a_m = '0;   // Captured upper raw bits
  logic [SMP_W-1:0] raw_b_m = '0;
  sample_t          mix_a_m = '0;   // Saturated mix
  sample_t          mix_b_m = '0;
  logic [SMP_W-1:0] dac_a_m = '0;   // DAC codes
  logic [SMP_W-1:0] dac_b_m = '0;
  int               win_m [AVG_LEN];
  int               wr_ptr   = 0;
  bit               model_ok = 1'b0;  // Known state after first reset edge
  int               cyc      = 0;
  int               err_cnt  = 0;
  int               chk_cnt  = 0;
  int               hi_cnt   = 0;
  int               lo_cnt   = 0;

  assign err_cnt_o    = err_cnt;
  assign chk_cnt_o    = chk_cnt;
  assign sat_hi_cnt_o = hi_cnt;
  assign sat_lo_cnt_o = lo_cnt;

  // Keep top bit, invert the 13 below
  function automatic logic [SMP_W-1:0] flip_mag(input logic [SMP_W-1:0] v);
    return v ^ {1'b0, {(SMP_W-1){1'b1}}};
  endfunction

  function automatic sample_t clamp(input int s);
    int c;
    c = s;
    if (c > SAT_MAX) c = SAT_MAX;
    if (c < SAT_MIN) c = SAT_MIN;
    return sample_t'(c);
  endfunction

  // floor(sum / 64); integer division alone truncates toward zero
  function automatic sample_t window_avg();
    int s;
    int q;
    s = 0;
    for (int i = 0; i < AVG_LEN; i++) begin
      s += win_m[i];
    end
    if (s >= 0) q = s / AVG_LEN;
    else        q = -((-s + AVG_LEN - 1) / AVG_LEN);
    return sample_t'(q);
  endfunction

  task automatic compare(input string name, input logic [SMP_W-1:0] got,
                         input logic [SMP_W-1:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("mismatch %s: got 0x%h expected 0x%h at cycle %0d", name, got, exp, cyc);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Compare pre-edge outputs, then step the model
  //////////////////////////////////////////////////////////////////////

  always @(posedge adc_clk) begin
    int sum_a;
    int sum_b;
    if (model_ok) begin
      compare("adc_a_o", acq_a_i, loop_en_i ? mix_a_m : flip_mag(raw_a_m));
      compare("adc_b_o", acq_b_i, loop_en_i ? mix_b_m : flip_mag(raw_b_m));
      compare("dac_a_o", dac_a_i, dac_a_m);
      compare("dac_b_o", dac_b_i, dac_b_m);
    end
    if (!adc_rstn) begin
      raw_a_m = '0;
      raw_b_m = '0;
      mix_a_m = '0;
      mix_b_m = '0;
      dac_a_m = '0;
      dac_b_m = '0;
      wr_ptr  = 0;
      for (int i = 0; i < AVG_LEN; i++) begin
        win_m[i] = 0;  // Window restarts empty
      end
      model_ok = 1'b1;
    end else begin
      dac_a_m        = flip_mag(window_avg());  // Window before new entry
      dac_b_m        = flip_mag(mix_b_m);
      win_m[wr_ptr]  = int'(mix_a_m);
      wr_ptr         = (wr_ptr + 1) % AVG_LEN;
      sum_a          = int'(gen_a_i) + int'(ctl_a_i);
      sum_b          = int'(gen_b_i) + int'(ctl_b_i);
      if (sum_b > SAT_MAX) hi_cnt++;  // Clamp coverage on channel B
      if (sum_b < SAT_MIN) lo_cnt++;
      mix_a_m        = clamp(sum_a);
      mix_b_m        = clamp(sum_b);
      raw_a_m        = adc_a_i[ADC_RAW_W-1:ADC_DROP_W];
      raw_b_m        = adc_b_i[ADC_RAW_W-1:ADC_DROP_W];
    end
    cyc++;
  end

endmodule

`default_nettype wire

/* dv/tb_analog_top.sv */
/*
 * Testbench top for the analog data path
 * Clock, reset, seeded random phases, DUT, checker, timeout, summary
 */

`timescale 1ns/1ps
`default_nettype none

module tb_analog_top;

  import analog_pkg::*;

  localparam int RST_CYC   = 16;
  localparam int PH_ADC    = 200;  // Raw ADC path, loopback off
  localparam int PH_LOOP   = 150;  // Loopback on
  localparam int PH_PRE    = 120;  // Stream before the mid-run reset
  localparam int PH_POST   = 200;  // Window refill after reset
  localparam int RUN_LEN   = 2*RST_CYC + PH_ADC + PH_LOOP + PH_PRE + PH_POST + 2;
  localparam int CYC_LIMIT = RUN_LEN + 100;

  logic                 adc_clk = 1'b0;
  logic                 adc_rstn;
  logic [ADC_RAW_W-1:0] adc_a_i;
  logic [ADC_RAW_W-1:0] adc_b_i;
  logic                 loop_en_i;
  sample_t              gen_a_i;
  sample_t              gen_b_i;
  sample_t              ctl_a_i;
  sample_t              ctl_b_i;
  sample_t              adc_a_o;
  sample_t              adc_b_o;
  logic [SMP_W-1:0]     dac_a_o;
  logic [SMP_W-1:0]     dac_b_o;
  int                   err_cnt;
  int                   chk_cnt;
  int                   sat_hi_cnt;
  int                   sat_lo_cnt;
  int                   other_err = 0;
  int                   cyc_cnt   = 0;

  always #50 adc_clk = ~adc_clk;  // 100 ns period

  analog_top i_dut (
    .adc_clk, .adc_rstn, .adc_a_i, .adc_b_i, .loop_en_i,
    .gen_a_i, .gen_b_i, .ctl_a_i, .ctl_b_i,
    .adc_a_o, .adc_b_o, .dac_a_o, .dac_b_o
  );

  analog_checker i_checker (
    .adc_clk, .adc_rstn, .adc_a_i, .adc_b_i, .loop_en_i,
    .gen_a_i, .gen_b_i, .ctl_a_i, .ctl_b_i,
    .acq_a_i (adc_a_o), .acq_b_i (adc_b_o), .dac_a_i (dac_a_o), .dac_b_i (dac_b_o),
    .err_cnt_o (err_cnt), .chk_cnt_o (chk_cnt),
    .sat_hi_cnt_o (sat_hi_cnt), .sat_lo_cnt_o (sat_lo_cnt)
  );

  bind dac_mixer analog_asserts i_analog_asserts (
    .adc_clk (adc_clk), .adc_rstn (adc_rstn), .sum_a_i (sum_a), .sum_b_i (sum_b),
    .mix_a_i (mix_a_o), .mix_b_i (mix_b_o)
  );

  // One in three near a range limit, so sums saturate often
  function automatic sample_t rand_sample();
    logic [31:0] r;
    logic [31:0] off;
    r   = $urandom();
    off = $urandom_range(63, 0);
    if ($urandom_range(2, 0) == 0) begin
      if (r[31]) return sample_t'(14'h1FFF - off[13:0]);
      else       return sample_t'(14'h2000 + off[13:0]);
    end
    return sample_t'(r[13:0]);
  endfunction

  function automatic logic [ADC_RAW_W-1:0] rand_raw();
    logic [31:0] r;
    r = $urandom();
    return r[ADC_RAW_W-1:0];
  endfunction

  task automatic drive_cycles(input int n, input logic rst_on, input logic loop);
    repeat (n) begin
      @(negedge adc_clk);
      adc_rstn  = ~rst_on;
      loop_en_i = loop;
      adc_a_i   = rand_raw();
      adc_b_i   = rand_raw();
      gen_a_i   = rand_sample();
      gen_b_i   = rand_sample();
      ctl_a_i   = rand_sample();
      ctl_b_i   = rand_sample();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus phases and summary
  //////////////////////////////////////////////////////////////////////

  initial begin
    adc_rstn  = 1'b0;
    loop_en_i = 1'b0;
    adc_a_i   = '0;
    adc_b_i   = '0;
    gen_a_i   = '0;
    gen_b_i   = '0;
    ctl_a_i   = '0;
    ctl_b_i   = '0;
    void'($urandom(32'h2e48));
    drive_cycles(RST_CYC - 1, 1'b1, 1'b0);  // First edge already in reset
    drive_cycles(PH_ADC, 1'b0, 1'b0);
    drive_cycles(PH_LOOP, 1'b0, 1'b1);
    drive_cycles(PH_PRE, 1'b0, 1'b0);
    drive_cycles(RST_CYC, 1'b1, 1'b0);      // Mid-run reset
    drive_cycles(PH_POST, 1'b0, 1'b0);
    @(negedge adc_clk);                     // Last compare done at prior rise
    if (chk_cnt == 0) begin
      $display("no DUT output was ever compared");
      other_err++;
    end
    if (sat_hi_cnt == 0) begin
      $display("channel B sum never exceeded the positive limit");
      other_err++;
    end
    if (sat_lo_cnt == 0) begin
      $display("channel B sum never fell below the negative limit");
      other_err++;
    end
    if (i_dut.i_dac_mixer.i_analog_asserts.fail_cnt != 0) begin
      $display("%0d mixer assertions failed",
               i_dut.i_dac_mixer.i_analog_asserts.fail_cnt);
      other_err++;
    end
    $display("summary: %0d mismatches, %0d other errors, %0d compares",
             err_cnt, other_err, chk_cnt);
    if (err_cnt == 0 && other_err == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Run guard
  always @(posedge adc_clk) begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt >= CYC_LIMIT) begin
      $display("timeout: run did not end within %0d cycles", CYC_LIMIT);
      $display("Finished with errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* sim.f */
rtl/analog_pkg.sv
rtl/adc_frontend.sv
rtl/dac_mixer.sv
rtl/boxcar_average.sv
rtl/dac_backend.sv
rtl/analog_top.sv
dv/analog_asserts.sv
dv/analog_checker.sv
dv/tb_analog_top.sv

/* Makefile */
# Verilator build and run for the analog data path testbench

SIM      := verilator
VFLAGS   := --binary --timing --assert -Wno-fatal -j 0
TOP      := tb_analog_top
FILELIST := sim.f
OBJ_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "FAIL: see $(LOG)"; exit 1; }
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
